// ==== pwmTop.f ====
source/pwmCfgPkg.sv
source/pwmBusPkg.sv
source/pwmRegDecode.sv
source/pwmPulseExecute.sv
source/pwmLossResult.sv
source/pwmTop.sv
bench/pwmClockGen.sv
bench/pwmTopTb.sv

// ==== bench/pwmTopTb.sv ====
`timescale 1ns/1ps

module pwmTopTb import pwmCfgPkg::*, pwmBusPkg::*; ();

    localparam int ackLimit       = 16;
    localparam int mainLen        = 100;
    localparam int randomLen      = 60;
    localparam int fixedPeriods   = 8;
    localparam int belowPeriods   = 12;
    localparam int randomPeriods  = 20;
    localparam int quietPeriods   = 20;
    localparam int lostPeriods    = 2 * quietPeriods + 6;
    localparam int disablePeriods = 8;
    localparam int marginCycles   = 1000;
    localparam int timeoutCycles  =
        (fixedPeriods + belowPeriods + lostPeriods + disablePeriods) * mainLen
        + randomPeriods * randomLen + marginCycles;

    // pulse width and carried remainder after one reload
    typedef struct packed {
        posT width;
        posT rem;
    } reloadResT;

    logic  clk;
    logic  rst;
    wbReqT wbReq;
    wbRspT wbRsp;
    posT   pulseDemand;
    logic  stepEnd;
    logic  pwm;

    logic [31:0] lfsrState = 32'h26dd;
    int          valueErrors = 0;
    int          otherErrors = 0;
    int          cycleCount = 0;
    string       testName = "reset";

    // reference state updated on the rising edge
    logic   mState = 1'b0;
    periodT mCnt = '0;
    periodT mPulse = '0;
    posT    mRem = '0;
    posT    mBase = '0;
    posT    mLost = '0;
    logic   mAck = 1'b0;
    periodT shPeriod = periodReset;
    periodT shMin = minPulseReset;
    logic   shEnable = 1'b0;
    posT    expQ[$];

    // run measurement updated on the falling edge
    int   runLen = 0;
    int   lastRise = -1;
    logic prevReload = 1'b0;
    logic spacingOn = 1'b0;

    pwmClockGen clockGen0 (
        .clk (clk),
        .rst (rst)
    );

    pwmTop dut0 (
        .clk         (clk),
        .rst         (rst),
        .wbReq       (wbReq),
        .wbRsp       (wbRsp),
        .pulseDemand (pulseDemand),
        .stepEnd     (stepEnd),
        .pwm         (pwm)
    );

    function automatic reloadResT reloadRef(input posT rem, input posT demand,
                                            input periodT minLen, input periodT perLen);
        logic [posW:0] wide;
        posT           sum;
        reloadResT     res;
        wide = {1'b0, rem} + {1'b0, demand};
        sum  = wide[posW] ? {posW{1'b1}} : wide[posW-1:0];
        if (sum >= posT'(minLen)) begin
            res.width = (sum < posT'(perLen)) ? sum : posT'(perLen);
            res.rem   = sum - res.width;
        end else begin
            res.width = '0;
            res.rem   = sum;
        end
        return res;
    endfunction

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function posT randBits(input int n);
        posT r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            r = {r[posW-2:0], lfsrState[0]};
        end
        return r;
    endfunction

    task automatic reportMismatch(input string what, input int expected, input int actual);
        valueErrors++;
        $display("[FAIL] %s %s: expected %0d, actual %0d", testName, what, expected, actual);
    endtask

    task automatic reportProblem(input string msg);
        otherErrors++;
        $display("error in %s: %s", testName, msg);
    endtask

    task automatic busAccess(input logic we, input regAddrT addr, input logic [31:0] wdata,
                             output logic [31:0] rdata);
        int waitCnt;
        @(posedge clk);
        wbReq.cyc  <= 1'b1;
        wbReq.stb  <= 1'b1;
        wbReq.we   <= we;
        wbReq.adr  <= addr;
        wbReq.datW <= wdata;
        waitCnt = 0;
        @(posedge clk);
        while (!wbRsp.ack && waitCnt < ackLimit) begin
            @(posedge clk);
            waitCnt++;
        end
        if (!wbRsp.ack) begin
            reportProblem($sformatf("no ack for access to address %0d", addr));
        end
        rdata = wbRsp.datR;
        wbReq.cyc <= 1'b0;
        wbReq.stb <= 1'b0;
        wbReq.we  <= 1'b0;
    endtask

    task automatic busWrite(input regAddrT addr, input logic [31:0] data);
        logic [31:0] unused;
        busAccess(1'b1, addr, data, unused);
    endtask

    task automatic readExpect(input regAddrT addr, input logic [31:0] expected,
                              input string what);
        logic [31:0] rdata;
        busAccess(1'b0, addr, '0, rdata);
        if (rdata !== expected) begin
            reportMismatch(what, expected, rdata);
        end
    endtask

    task automatic setDemand(input posT value);
        @(posedge clk);
        pulseDemand <= value;
    endtask

    task automatic waitCycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    // pwm low this cycle and the next one holds no reload
    task automatic waitQuiet();
        int waitCnt;
        waitCnt = 0;
        @(negedge clk);
        while (!(mState && !pwm && mPulse == '0 && mCnt > periodT'(3))
               && waitCnt < quietPeriods * mainLen) begin
            @(negedge clk);
            waitCnt++;
        end
        if (waitCnt >= quietPeriods * mainLen) begin
            reportProblem("pwm never stayed low away from a reload");
        end
    endtask

    task automatic issueStepEnd();
        @(posedge clk);
        stepEnd <= 1'b1;
        @(posedge clk);
        stepEnd <= 1'b0;
    endtask

    // reference model of the generator and of the bus handshake
    always @(posedge clk) begin
        reloadResT res;
        logic      accept;
        if (rst || !shEnable) begin
            // a pulse cut by the disable is shorter than queued
            if (mPulse > periodT'(1) && expQ.size() > 0) begin
                expQ[expQ.size() - 1] = expQ[expQ.size() - 1] - posT'(mPulse - periodT'(1));
            end
            mState = 1'b0;
            mCnt   = '0;
            mPulse = '0;
            mRem   = '0;
            mBase  = '0;
            mLost  = '0;
        end else begin
            if (stepEnd) begin
                mLost = mRem - mBase;
                mBase = mRem;
            end
            if (mPulse != '0) begin
                mPulse = mPulse - periodT'(1);
            end
            if (!mState) begin
                mState = 1'b1;
                mCnt   = shPeriod;
            end else if (mCnt == periodT'(1)) begin
                res  = reloadRef(mRem, pulseDemand, shMin, shPeriod);
                mRem = res.rem;
                mCnt = shPeriod;
                if (res.width != '0) begin
                    mPulse = periodT'(res.width);
                    expQ.push_back(res.width);
                end
            end else begin
                mCnt = mCnt - periodT'(1);
            end
        end
        if (rst) begin
            mAck     = 1'b0;
            shPeriod = periodReset;
            shMin    = minPulseReset;
            shEnable = 1'b0;
        end else begin
            if (wbRsp.ack !== mAck) begin
                reportProblem("ack does not follow the classic handshake");
            end
            accept = wbReq.cyc && wbReq.stb && !mAck;
            if (accept && wbReq.we) begin
                case (wbReq.adr)
                    addrPeriod:   shPeriod = wbReq.datW[periodW-1:0];
                    addrMinPulse: shMin    = wbReq.datW[periodW-1:0];
                    addrControl:  shEnable = wbReq.datW[ctrlEnableBit];
                    default:      ;
                endcase
            end
            mAck = accept;
        end
    end

    // a pwm high run always ends by the reload cycle
    always @(negedge clk) begin
        logic isReload;
        posT  expected;
        isReload = mState && (mCnt == periodT'(1));
        if (pwm === 1'b1) begin
            if (runLen == 0) begin
                if (!prevReload) begin
                    reportProblem("pwm rose in a cycle that does not follow a reload");
                end
                if (spacingOn && lastRise >= 0 && cycleCount - lastRise != int'(shPeriod)) begin
                    reportMismatch("rise spacing", shPeriod, cycleCount - lastRise);
                end
                lastRise = cycleCount;
            end
            runLen++;
        end
        if (runLen > 0 && (pwm !== 1'b1 || isReload)) begin
            if (expQ.size() == 0) begin
                reportProblem($sformatf("pwm run of %0d cycles with no pulse due", runLen));
            end else begin
                expected = expQ.pop_front();
                if (expected != posT'(runLen)) begin
                    reportMismatch("pulse width", expected, runLen);
                end
            end
            runLen = 0;
        end
        prevReload = isReload;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > timeoutCycles) begin
            $display("timeout: run passed %0d cycles", timeoutCycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        logic [31:0] rdata;
        wbReq       = '0;
        pulseDemand = '0;
        stepEnd     = 1'b0;
        @(negedge rst);

        testName = "registers";
        readExpect(addrPeriod, 32'(periodReset), "period after reset");
        readExpect(addrMinPulse, 32'(minPulseReset), "minimum pulse after reset");
        readExpect(addrControl, 32'd0, "control after reset");
        busWrite(addrPeriod, mainLen);
        busWrite(addrMinPulse, 20);
        readExpect(addrPeriod, mainLen, "period readback");
        readExpect(addrMinPulse, 32'd20, "minimum pulse readback");
        busWrite(addrLost, 32'h1234);
        readExpect(addrLost, 32'd0, "lost after write");
        readExpect(regAddrT'(6), 32'd0, "unmapped read");
        if (pwm !== 1'b0) begin
            reportProblem("pwm is not low while disabled");
        end
        busWrite(addrControl, 1);
        readExpect(addrControl, 32'd1, "control readback");

        testName  = "fixed demand";
        spacingOn = 1'b1;
        setDemand(40);
        waitCycles(fixedPeriods * mainLen);
        spacingOn = 1'b0;

        testName = "below minimum";
        setDemand(7);
        waitCycles(belowPeriods * mainLen);

        testName = "above period";
        busWrite(addrPeriod, randomLen);
        repeat (randomPeriods) begin
            setDemand(randBits(7));
            waitCycles(randomLen - 1);
        end

        // remainder climbs 15 per period until it reaches 50
        testName = "lost value";
        busWrite(addrPeriod, mainLen);
        busWrite(addrMinPulse, 50);
        setDemand(15);
        repeat (2) begin
            waitQuiet();
            issueStepEnd();
            busAccess(1'b0, addrLost, '0, rdata);
            if (rdata !== 32'(mLost)) begin
                reportMismatch("lost", mLost, rdata);
            end
            waitCycles(3 * mainLen);
        end

        // demand above the period keeps pwm high and leaves a remainder
        testName = "disable";
        setDemand(130);
        waitCycles(mainLen);
        @(negedge clk);
        while (pwm !== 1'b1) begin
            @(negedge clk);
        end
        busWrite(addrControl, 0);
        @(negedge clk);
        if (pwm !== 1'b0) begin
            reportProblem("pwm still high after enable was cleared");
        end
        readExpect(addrLost, 32'd0, "lost after disable");
        // a carried remainder would widen the first pulse
        setDemand(60);
        busWrite(addrControl, 1);
        waitCycles(5 * mainLen);

        testName = "final drain";
        busWrite(addrControl, 0);
        waitCycles(3);
        if (expQ.size() != 0) begin
            reportProblem($sformatf("%0d expected pulses never appeared", expQ.size()));
        end

        $display("value errors %0d, other errors %0d", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== bench/pwmClockGen.sv ====
`timescale 1ns/1ps

module pwmClockGen (
    output logic clk,
    output logic rst
);

    // 100 ns period
    localparam int halfPeriod  = 50;
    localparam int resetCycles = 5;

    initial begin
        clk = 1'b0;
        forever begin
            #halfPeriod clk = ~clk;
        end
    end

    // reset released on a rising edge like any other input
    initial begin
        rst = 1'b1;
        repeat (resetCycles) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// ==== source/pwmTop.sv ====
`timescale 1ns/1ps

module pwmTop import pwmCfgPkg::*, pwmBusPkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  wbReqT wbReq,
    output wbRspT wbRsp,
    input  posT   pulseDemand,
    input  logic  stepEnd,
    output logic  pwm
);

    genCfgT  cfg;
    execEvtT evt;
    posT     lost;

    // bus slave and configuration registers
    pwmRegDecode regDecode0 (
        .clk   (clk),
        .rst   (rst),
        .wbReq (wbReq),
        .wbRsp (wbRsp),
        .lost  (lost),
        .cfg   (cfg)
    );

    // period, remainder and pulse counters
    pwmPulseExecute pulseExecute0 (
        .clk         (clk),
        .rst         (rst),
        .cfg         (cfg),
        .pulseDemand (pulseDemand),
        .evt         (evt),
        .pwm         (pwm)
    );

    // wanted versus delivered per commutation step
    pwmLossResult lossResult0 (
        .clk     (clk),
        .rst     (rst),
        .evt     (evt),
        .enable  (cfg.enable),
        .stepEnd (stepEnd),
        .lost    (lost)
    );

endmodule

// ==== source/pwmLossResult.sv ====
`timescale 1ns/1ps

module pwmLossResult import pwmCfgPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  execEvtT evt,
    input  logic    enable,
    input  logic    stepEnd,
    output posT     lost
);

    posT wantTotal;
    posT realTotal;
    posT wantAdd;
    posT realAdd;

    // what this cycle contributes to each total
    assign wantAdd = evt.reload ? evt.demand : '0;
    assign realAdd = evt.pulseOn ? posT'(1) : '0;

    always_ff @(posedge clk) begin
        if (rst || !enable) begin
            wantTotal <= '0;
            realTotal <= '0;
        end else if (stepEnd) begin
            // events on the boundary cycle belong to the new step
            wantTotal <= wantAdd;
            realTotal <= realAdd;
        end else begin
            wantTotal <= wantTotal + wantAdd;
            realTotal <= realTotal + realAdd;
        end
    end

    // demand not yet delivered when the step closes
    always_ff @(posedge clk) begin
        if (rst || !enable) begin
            lost <= '0;
        end else if (stepEnd) begin
            lost <= wantTotal - realTotal;
        end
    end

endmodule

// ==== source/pwmPulseExecute.sv ====
`timescale 1ns/1ps

module pwmPulseExecute import pwmCfgPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  genCfgT  cfg,
    input  posT     pulseDemand,
    output execEvtT evt,
    output logic    pwm
);

    runStateT      state;
    periodT        periodCnt;
    periodT        pulseCnt;
    posT           remainder;
    logic          clear;
    logic          reload;
    logic [posW:0] sumWide;
    posT           sum;
    posT           pulseLen;
    logic          pulseStart;

    // disable behaves like reset for every counter
    assign clear = rst || !cfg.enable;

    // last cycle of the period
    assign reload = (state == running) && (periodCnt == periodT'(1));

    // carried remainder plus the new demand, saturated
    assign sumWide = {1'b0, remainder} + {1'b0, pulseDemand};
    assign sum     = sumWide[posW] ? '1 : sumWide[posW-1:0];

    // too short a pulse would not switch the power stage cleanly
    assign pulseStart = (sum >= posT'(cfg.minPulse));

    // a pulse never runs past the period, the excess is carried
    assign pulseLen = (sum > posT'(cfg.periodLen)) ? posT'(cfg.periodLen) : sum;

    always_ff @(posedge clk) begin
        if (clear) begin
            state     <= idle;
            periodCnt <= '0;
        end else begin
            case (state)
                idle: begin
                    periodCnt <= cfg.periodLen;
                    state     <= running;
                end
                running: begin
                    if (reload) begin
                        periodCnt <= cfg.periodLen;
                    end else begin
                        periodCnt <= periodCnt - periodT'(1);
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (clear) begin
            remainder <= '0;
        end else if (reload) begin
            if (pulseStart) begin
                remainder <= sum - pulseLen;
            end else begin
                remainder <= sum;
            end
        end
    end

    // pulse counter, pwm is high while it is nonzero
    always_ff @(posedge clk) begin
        if (clear) begin
            pulseCnt <= '0;
        end else if (reload && pulseStart) begin
            pulseCnt <= periodT'(pulseLen);
        end else if (pulseCnt != '0) begin
            pulseCnt <= pulseCnt - periodT'(1);
        end
    end

    assign pwm = (pulseCnt != '0);

    assign evt.reload  = reload;
    assign evt.demand  = pulseDemand;
    assign evt.pulseOn = pwm;

endmodule

// ==== source/pwmRegDecode.sv ====
`timescale 1ns/1ps

module pwmRegDecode import pwmCfgPkg::*, pwmBusPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  wbReqT  wbReq,
    output wbRspT  wbRsp,
    input  posT    lost,
    output genCfgT cfg
);

    logic    request;
    logic    accept;
    logic    ack;
    regAddrT addr;
    wbDatT   readMux;
    wbDatT   readData;
    periodT  periodReg;
    periodT  minPulseReg;
    logic    enableReg;

    assign request = wbReq.cyc && wbReq.stb;
    assign addr    = wbReq.adr;

    // a request is taken only when it is not the one being acknowledged
    assign accept = request && !ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            ack <= 1'b0;
        end else begin
            ack <= accept;
        end
    end

    // register writes land on the edge that raises ack
    always_ff @(posedge clk) begin
        if (rst) begin
            periodReg   <= periodReset;
            minPulseReg <= minPulseReset;
            enableReg   <= 1'b0;
        end else if (accept && wbReq.we) begin
            case (addr)
                addrPeriod: begin
                    periodReg <= wbReq.datW[periodW-1:0];
                end
                addrMinPulse: begin
                    minPulseReg <= wbReq.datW[periodW-1:0];
                end
                addrControl: begin
                    enableReg <= wbReq.datW[ctrlEnableBit];
                end
                // lost and unmapped words ignore writes
                default: begin
                end
            endcase
        end
    end

    always_comb begin
        readMux = '0;
        case (addr)
            addrPeriod: begin
                readMux = wbDatT'(periodReg);
            end
            addrMinPulse: begin
                readMux = wbDatT'(minPulseReg);
            end
            addrControl: begin
                readMux[ctrlEnableBit] = enableReg;
            end
            addrLost: begin
                readMux = wbDatT'(lost);
            end
            default: begin
                readMux = '0;
            end
        endcase
    end

    // read data is captured together with ack and held while it is high
    always_ff @(posedge clk) begin
        if (accept) begin
            readData <= readMux;
        end
    end

    assign wbRsp.ack  = ack;
    assign wbRsp.datR = readData;

    assign cfg.periodLen = periodReg;
    assign cfg.minPulse  = minPulseReg;
    assign cfg.enable    = enableReg;

endmodule

// ==== source/pwmBusPkg.sv ====
package pwmBusPkg;

    // Wishbone classic bus widths
    localparam int wbAdrW = 3;
    localparam int wbDatW = 32;

    // word address on the bus
    typedef logic [wbAdrW-1:0] wbAdrT;

    // data word on the bus
    typedef logic [wbDatW-1:0] wbDatT;

    // master to slave
    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        wbAdrT adr;
        wbDatT datW;
    } wbReqT;

    // slave to master
    typedef struct packed {
        logic  ack;
        wbDatT datR;
    } wbRspT;

endpackage

// ==== source/pwmCfgPkg.sv ====
package pwmCfgPkg;

    // widths of the generator quantities
    localparam int periodW  = 12;
    localparam int posW     = 16;
    localparam int regAddrW = 3;

    // period or pulse length in clock cycles
    typedef logic [periodW-1:0] periodT;

    // accumulated position, remainder or lost value
    typedef logic [posW-1:0] posT;

    // register word address
    typedef logic [regAddrW-1:0] regAddrT;

    // register map
    localparam regAddrT addrPeriod   = regAddrT'(0);
    localparam regAddrT addrMinPulse = regAddrT'(1);
    localparam regAddrT addrControl  = regAddrT'(2);
    // read only, writes are dropped
    localparam regAddrT addrLost     = regAddrT'(3);

    // enable position inside the control word
    localparam int ctrlEnableBit = 0;

    // 511 cycles at 10 MHz is about 51 us, 32 cycles covers the driver edges
    localparam periodT periodReset   = periodT'(511);
    localparam periodT minPulseReset = periodT'(32);

    typedef enum logic {
        idle,
        running
    } runStateT;

    typedef struct packed {
        periodT periodLen;
        periodT minPulse;
        logic   enable;
    } genCfgT;

    // one entry per cycle from the pulse engine to the loss tracker
    typedef struct packed {
        logic reload;
        posT  demand;
        logic pulseOn;
    } execEvtT;

endpackage
